//--- src/dac_pkg.sv
package dac_pkg;

	////////////////////////////////////////////////////////////////////////////
	// data path widths
	////////////////////////////////////////////////////////////////////////////

	localparam int W_DATA  = 16;               // dac data word
	localparam int W_CHS   = 3;                // channel field in an instruction
	localparam int N_CHAN  = 8;                // dac channels on the board
	localparam int W_INSTR = W_CHS + W_DATA;   // {channel, data}
	localparam int W_FRAME = 24;               // serial frame, opcode + addr + data
	localparam int W_DIV   = 8;                // sclk divider field

	// host register port
	localparam int W_CFG_ADDR = 2;
	localparam int W_CFG_DATA = 8;             // wide enough for mask and divider

	localparam logic [W_CFG_ADDR-1:0] REG_MASK   = 2'd0; // channel enables
	localparam logic [W_CFG_ADDR-1:0] REG_MODE   = 2'd1; // bit 0 selects update
	localparam logic [W_CFG_ADDR-1:0] REG_DIV    = 2'd2; // sclk half period - 1
	localparam logic [W_CFG_ADDR-1:0] REG_STATUS = 2'd3; // bit 0 sticky overflow

	// dac command nibble, first four bits on sdi
	typedef enum logic [3:0] {
		CMD_WRITE        = 4'b0000,          // write input register only
		CMD_WRITE_UPDATE = 4'b0011           // write and update the output
	} dac_cmd_e;

	// serial controller states
	typedef enum logic [1:0] {
		ST_IDLE,                             // wait for an instruction
		ST_LOAD,                             // mask check, build frame
		ST_SHIFT,                            // sync_n low, clocking bits out
		ST_GAP                               // sync_n high between frames
	} ctrl_state_e;

endpackage

//--- src/dac_instr_queue.sv
`timescale 1ns/1ns

module dac_instr_queue (
	input  logic                                       clk_in,
	input  logic                                       rst_n,
	input  logic [dac_pkg::N_CHAN*dac_pkg::W_DATA-1:0] data_packed, // all channels, ch 1 in lsbs
	input  logic [dac_pkg::N_CHAN-1:0]                 data_valid,  // one strobe per channel
	output logic [dac_pkg::W_INSTR-1:0]                fifo_din,    // {channel, data}
	output logic                                       fifo_wr_en
);

	localparam int HALF  = dac_pkg::N_CHAN / 2;   // channels per half
	localparam int W_SEL = $clog2(HALF);          // word select within a half
	localparam int W_BUS = HALF * dac_pkg::W_DATA; // packed width of a half

	////////////////////////////////////////////////////////////////////////////
	// half split
	////////////////////////////////////////////////////////////////////////////

	logic [W_BUS-1:0]                data_lo, data_hi;
	logic [HALF-1:0]                 dv_lo, dv_hi;
	logic                            any_lo, any_hi;    // a strobe in this half
	logic [W_SEL-1:0]                sel_lo, sel_hi;
	logic [dac_pkg::W_DATA-1:0]      word_lo, word_hi;
	logic [dac_pkg::W_CHS-1:0]       chan_lo, chan_hi;
	logic [dac_pkg::W_INSTR-1:0]     instr_lo, instr_hi;

	// upper half held back one cycle
	logic [dac_pkg::W_INSTR-1:0]     instr_hi_q;
	logic                            vld_hi_q;

	// one-hot strobe to word index, zero when idle
	function automatic logic [W_SEL-1:0] oh_to_bin(input logic [HALF-1:0] oh);
		logic [W_SEL-1:0] idx;
		idx = '0;
		for (int i = 0; i < HALF; i++) begin
			if (oh[i])
				idx = idx | W_SEL'(i); // only one bit set, so or is enough
		end
		return idx;
	endfunction

	assign data_lo = data_packed[W_BUS-1:0];
	assign data_hi = data_packed[2*W_BUS-1:W_BUS];
	assign dv_lo   = data_valid[HALF-1:0];
	assign dv_hi   = data_valid[dac_pkg::N_CHAN-1:HALF];

	assign any_lo = |dv_lo;
	assign any_hi = |dv_hi;

	assign sel_lo = oh_to_bin(dv_lo);
	assign sel_hi = oh_to_bin(dv_hi);

	////////////////////////////////////////////////////////////////////////////
	// word select and channel tag
	////////////////////////////////////////////////////////////////////////////

	assign word_lo = data_lo[sel_lo*dac_pkg::W_DATA +: dac_pkg::W_DATA];
	assign word_hi = data_hi[sel_hi*dac_pkg::W_DATA +: dac_pkg::W_DATA];

	assign chan_lo = dac_pkg::W_CHS'(sel_lo);
	assign chan_hi = dac_pkg::W_CHS'(sel_hi) + dac_pkg::W_CHS'(HALF); // channels 5-8 -> 4..7

	assign instr_lo = {chan_lo, word_lo};
	assign instr_hi = {chan_hi, word_hi};

	// upper instruction, payload only
	always_ff @(posedge clk_in) begin
		instr_hi_q <= instr_hi;
	end

	// upper strobe delay
	always_ff @(posedge clk_in) begin
		if (!rst_n)
			vld_hi_q <= 1'b0;
		else
			vld_hi_q <= any_hi;
	end

	////////////////////////////////////////////////////////////////////////////
	// fifo write source
	////////////////////////////////////////////////////////////////////////////

	// lower half goes straight in; upper follows a cycle later
	// strobe rule keeps both from landing on the same cycle
	assign fifo_din   = any_lo ? instr_lo : instr_hi_q;
	assign fifo_wr_en = any_lo | vld_hi_q;

endmodule

//--- src/dac_instr_fifo.sv
`timescale 1ns/1ns

module dac_instr_fifo #(
	parameter int FIFO_DEPTH = 16                   // power of two, two or more
) (
	input  logic                         clk_in,
	input  logic                         rst_n,
	input  logic [dac_pkg::W_INSTR-1:0]  din,
	input  logic                         wr_en,
	input  logic                         rd_ack,     // pops the head
	output logic [dac_pkg::W_INSTR-1:0]  dout,       // head word, good while valid
	output logic                         valid,
	output logic                         overflow    // one cycle per lost write
);

	localparam int W_PTR = $clog2(FIFO_DEPTH);
	localparam int W_CNT = W_PTR + 1;             // holds 0..FIFO_DEPTH

	logic [dac_pkg::W_INSTR-1:0] mem [FIFO_DEPTH];
	logic [W_PTR-1:0]            wr_ptr_q, rd_ptr_q; // wrap on their own
	logic [W_CNT-1:0]            count_q;
	logic                        full;
	logic                        do_wr, do_rd;

	assign full  = (count_q == W_CNT'(FIFO_DEPTH));
	assign valid = (count_q != '0);
	assign dout  = mem[rd_ptr_q];                   // first word falls through

	assign do_wr = wr_en & ~full;
	assign do_rd = rd_ack & valid;                  // pop on empty is ignored

	// storage
	always_ff @(posedge clk_in) begin
		if (do_wr)
			mem[wr_ptr_q] <= din;
	end

	////////////////////////////////////////////////////////////////////////////
	// pointers and fill count
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_wr)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (do_rd)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;      // both or neither
			endcase
			overflow <= wr_en & full;           // write dropped this cycle
		end
	end

endmodule

//--- src/dac_serial_ctrl.sv
`timescale 1ns/1ns

module dac_serial_ctrl (
	input  logic                         clk_in,
	input  logic                         rst_n,
	input  logic [dac_pkg::W_INSTR-1:0]  fifo_dout,
	input  logic                         fifo_valid,
	input  logic [dac_pkg::N_CHAN-1:0]   chan_mask,   // 1 = channel enabled
	input  logic                         update_mode, // 1 = write and update
	input  logic [dac_pkg::W_DIV-1:0]    sclk_div,    // half period = div+1 clocks
	output logic                         rd_ack,
	output logic                         sclk,
	output logic                         sdi,
	output logic                         sync_n
);

	localparam int W_BIT = $clog2(dac_pkg::W_FRAME);

	dac_pkg::ctrl_state_e        state_q;
	dac_pkg::dac_cmd_e           cmd;
	logic [dac_pkg::W_INSTR-1:0] instr_q;          // latched head
	logic [dac_pkg::W_CHS-1:0]   instr_chan;
	logic [dac_pkg::W_DATA-1:0]  instr_data;
	logic [dac_pkg::W_FRAME-1:0] shift_q;          // frame, msb goes out first
	logic [dac_pkg::W_DIV-1:0]   div_q;            // divider held for the frame
	logic [dac_pkg::W_DIV-1:0]   div_cnt_q;
	logic [W_BIT-1:0]            bit_cnt_q;
	logic                        gap_cnt_q;        // two gap clocks
	logic                        half_done;        // sclk phase ends this cycle

	assign {instr_chan, instr_data} = instr_q;
	assign cmd       = update_mode ? dac_pkg::CMD_WRITE_UPDATE : dac_pkg::CMD_WRITE;
	assign rd_ack    = (state_q == dac_pkg::ST_IDLE) && fifo_valid; // pop as we latch
	assign half_done = (div_cnt_q == div_q);

	////////////////////////////////////////////////////////////////////////////
	// instruction and frame payload
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (rd_ack)
			instr_q <= fifo_dout;
		if (state_q == dac_pkg::ST_LOAD) begin
			shift_q <= {cmd, 1'b0, instr_chan, instr_data}; // 4 + 4 + 16
			div_q   <= sclk_div;
		end else if (state_q == dac_pkg::ST_SHIFT && half_done && sclk) begin
			shift_q <= shift_q << 1;                       // next bit on falling edge
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// fsm and pin drivers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			state_q   <= dac_pkg::ST_IDLE;
			sclk      <= 1'b0;
			sdi       <= 1'b0;
			sync_n    <= 1'b1;
			div_cnt_q <= '0;
			bit_cnt_q <= '0;
			gap_cnt_q <= 1'b0;
		end else begin
			case (state_q)
				dac_pkg::ST_IDLE: begin
					if (fifo_valid)
						state_q <= dac_pkg::ST_LOAD;
				end
				dac_pkg::ST_LOAD: begin
					if (chan_mask[instr_chan]) begin
						sync_n    <= 1'b0;         // frame starts, sclk low phase first
						sdi       <= cmd[3];       // opcode msb
						div_cnt_q <= '0;
						bit_cnt_q <= '0;
						state_q   <= dac_pkg::ST_SHIFT;
					end else begin
						state_q <= dac_pkg::ST_IDLE; // masked, already popped
					end
				end
				dac_pkg::ST_SHIFT: begin
					if (half_done) begin
						div_cnt_q <= '0;
						if (!sclk) begin
							sclk <= 1'b1;            // dac samples sdi here
						end else begin
							sclk <= 1'b0;
							if (bit_cnt_q == W_BIT'(dac_pkg::W_FRAME - 1)) begin
								sync_n    <= 1'b1;   // last period done
								sdi       <= 1'b0;
								gap_cnt_q <= 1'b0;
								state_q   <= dac_pkg::ST_GAP;
							end else begin
								bit_cnt_q <= bit_cnt_q + 1'b1;
								sdi       <= shift_q[dac_pkg::W_FRAME-2];
							end
						end
					end else begin
						div_cnt_q <= div_cnt_q + 1'b1;
					end
				end
				dac_pkg::ST_GAP: begin
					gap_cnt_q <= 1'b1;
					if (gap_cnt_q)
						state_q <= dac_pkg::ST_IDLE;
				end
				default: state_q <= dac_pkg::ST_IDLE;
			endcase
		end
	end

endmodule

//--- src/dac_cfg_regs.sv
`timescale 1ns/1ns

module dac_cfg_regs (
	input  logic                            clk_in,
	input  logic                            rst_n,
	input  logic                            cfg_wr,
	input  logic [dac_pkg::W_CFG_ADDR-1:0]  cfg_addr,
	input  logic [dac_pkg::W_CFG_DATA-1:0]  cfg_wdata,
	input  logic                            overflow,    // pulse from the fifo
	output logic [dac_pkg::W_CFG_DATA-1:0]  cfg_rdata,
	output logic [dac_pkg::N_CHAN-1:0]      chan_mask,
	output logic                            update_mode,
	output logic [dac_pkg::W_DIV-1:0]       sclk_div
);

	logic ovf_q;                                   // sticky overflow

	////////////////////////////////////////////////////////////////////////////
	// register writes
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			chan_mask   <= '1;                       // all channels on
			update_mode <= 1'b1;
			sclk_div    <= dac_pkg::W_DIV'(1);
			ovf_q       <= 1'b0;
		end else begin
			if (cfg_wr) begin
				case (cfg_addr)
					dac_pkg::REG_MASK:   chan_mask   <= cfg_wdata[dac_pkg::N_CHAN-1:0];
					dac_pkg::REG_MODE:   update_mode <= cfg_wdata[0];
					dac_pkg::REG_DIV:    sclk_div    <= cfg_wdata[dac_pkg::W_DIV-1:0];
					dac_pkg::REG_STATUS: ovf_q       <= 1'b0; // any write clears
					default: ;
				endcase
			end
			if (overflow)
				ovf_q <= 1'b1;                         // new event wins over clear
		end
	end

	// read mux, straight from the address
	always_comb begin
		cfg_rdata = '0;
		case (cfg_addr)
			dac_pkg::REG_MASK:   cfg_rdata[dac_pkg::N_CHAN-1:0] = chan_mask;
			dac_pkg::REG_MODE:   cfg_rdata[0] = update_mode;
			dac_pkg::REG_DIV:    cfg_rdata[dac_pkg::W_DIV-1:0] = sclk_div;
			dac_pkg::REG_STATUS: cfg_rdata[0] = ovf_q;
			default:             cfg_rdata = '0;
		endcase
	end

endmodule

//--- src/dac_out_top.sv
`timescale 1ns/1ns

module dac_out_top #(
	parameter int FIFO_DEPTH = 16                  // instruction buffer depth
) (
	input  logic                                       clk_in,
	input  logic                                       rst_n,
	input  logic [dac_pkg::N_CHAN*dac_pkg::W_DATA-1:0] data_packed,
	input  logic [dac_pkg::N_CHAN-1:0]                 data_valid,
	input  logic                                       cfg_wr,
	input  logic [dac_pkg::W_CFG_ADDR-1:0]             cfg_addr,
	input  logic [dac_pkg::W_CFG_DATA-1:0]             cfg_wdata,
	output logic [dac_pkg::W_CFG_DATA-1:0]             cfg_rdata,
	output logic                                       sclk,
	output logic                                       sdi,
	output logic                                       sync_n
);

	////////////////////////////////////////////////////////////////////////////
	// internal nets
	////////////////////////////////////////////////////////////////////////////

	logic [dac_pkg::W_INSTR-1:0] fifo_din;         // queue -> fifo
	logic                        fifo_wr_en;
	logic [dac_pkg::W_INSTR-1:0] fifo_dout;        // fifo -> controller
	logic                        fifo_valid;
	logic                        rd_ack;           // controller pop
	logic                        overflow;         // fifo -> status
	logic [dac_pkg::N_CHAN-1:0]  chan_mask;        // regs -> controller
	logic                        update_mode;
	logic [dac_pkg::W_DIV-1:0]   sclk_div;

	dac_instr_queue u_queue (
		.clk_in      (clk_in),
		.rst_n       (rst_n),
		.data_packed (data_packed),
		.data_valid  (data_valid),
		.fifo_din    (fifo_din),
		.fifo_wr_en  (fifo_wr_en)
	);

	dac_instr_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.clk_in   (clk_in),
		.rst_n    (rst_n),
		.din      (fifo_din),
		.wr_en    (fifo_wr_en),
		.rd_ack   (rd_ack),
		.dout     (fifo_dout),
		.valid    (fifo_valid),
		.overflow (overflow)
	);

	dac_serial_ctrl u_ctrl (
		.clk_in      (clk_in),
		.rst_n       (rst_n),
		.fifo_dout   (fifo_dout),
		.fifo_valid  (fifo_valid),
		.chan_mask   (chan_mask),
		.update_mode (update_mode),
		.sclk_div    (sclk_div),
		.rd_ack      (rd_ack),
		.sclk        (sclk),
		.sdi         (sdi),
		.sync_n      (sync_n)
	);

	dac_cfg_regs u_regs (
		.clk_in      (clk_in),
		.rst_n       (rst_n),
		.cfg_wr      (cfg_wr),
		.cfg_addr    (cfg_addr),
		.cfg_wdata   (cfg_wdata),
		.overflow    (overflow),
		.cfg_rdata   (cfg_rdata),
		.chan_mask   (chan_mask),
		.update_mode (update_mode),
		.sclk_div    (sclk_div)
	);

endmodule

//--- dv/dac_clk_gen.sv
`timescale 1ns/1ns

module dac_clk_gen #(
	parameter int PERIOD_NS    = 40,   // 25 MHz system clock
	parameter int RESET_CYCLES = 5
) (
	output logic clk_in,
	output logic rst_n
);

	initial begin
		clk_in = 1'b0;
		forever #(PERIOD_NS / 2) clk_in = ~clk_in;
	end

	// sync reset, released on a falling edge away from the sampling edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_in);
		@(negedge clk_in);
		rst_n = 1'b1;
	end

endmodule

//--- dv/dac_out_tb.sv
`timescale 1ns/1ns

module dac_out_tb;

	localparam int CLK_PERIOD = 40;
	localparam int FIFO_DEPTH = 16;
	localparam int N_CHAN     = dac_pkg::N_CHAN;
	localparam int W_DATA     = dac_pkg::W_DATA;
	localparam int W_FRAME    = dac_pkg::W_FRAME;
	localparam int W_CFG_DATA = dac_pkg::W_CFG_DATA;
	localparam int N_BURST    = 4;     // random bursts per divider
	localparam int BURST_LEN  = 6;     // cycles per burst, stays below the fifo size

	// clocks for one frame at a divider, gap and load included
	function automatic int frame_cycles(input int div);
		return W_FRAME * 2 * (div + 1) + 4;
	endfunction

	localparam int LIMIT = 20 * frame_cycles(1)
		+ 2 * N_BURST * BURST_LEN * (frame_cycles(0) + frame_cycles(3))
		+ (FIFO_DEPTH + 1) * frame_cycles(255) + 6 * 1000;

	logic                                clk_in, rst_n;
	logic [N_CHAN*W_DATA-1:0]            data_packed;
	logic [N_CHAN-1:0]                   data_valid;
	logic                                cfg_wr;
	logic [dac_pkg::W_CFG_ADDR-1:0]      cfg_addr;
	logic [W_CFG_DATA-1:0]               cfg_wdata, cfg_rdata;
	logic                                sclk, sdi, sync_n;

	logic [W_FRAME-1:0] model[$];      // frames still owed by the dut
	logic [N_CHAN-1:0]  cur_mask;      // shadow of the config registers
	logic               cur_mode;
	logic [7:0]         cur_div;
	int                 accepted, keep_limit; // fifo capacity model for overflow
	int                 errors, err_mark, tests_run, tests_failed, cycles;
	logic [W_FRAME-1:0] cap_frame;
	int                 cap_bits;
	time                last_rise;

	dac_clk_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(5)) u_clk (.clk_in(clk_in), .rst_n(rst_n));

	dac_out_top #(.FIFO_DEPTH(FIFO_DEPTH)) UUT (
		.clk_in(clk_in), .rst_n(rst_n), .data_packed(data_packed), .data_valid(data_valid),
		.cfg_wr(cfg_wr), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata),
		.sclk(sclk), .sdi(sdi), .sync_n(sync_n)
	);

	////////////////////////////////////////////////////////////////////////////
	// reference model and compare tasks
	////////////////////////////////////////////////////////////////////////////

	// opcode, zero, channel, data
	function automatic logic [W_FRAME-1:0] expected_frame(input logic [2:0] chan,
			input logic [W_DATA-1:0] data, input logic mode);
		dac_pkg::dac_cmd_e op;
		op = mode ? dac_pkg::CMD_WRITE_UPDATE : dac_pkg::CMD_WRITE;
		return {op, 1'b0, chan, data};
	endfunction

	task automatic check_frame(input string name, input logic [W_FRAME-1:0] act, exp);
		if (act !== exp) begin
			$display("mismatch %s: got 0x%06h expected 0x%06h", name, act, exp);
			errors++;
		end
	endtask

	task automatic check_reg(input string name, input logic [W_CFG_DATA-1:0] act, exp);
		if (act !== exp) begin
			$display("mismatch %s: got 0x%02h expected 0x%02h", name, act, exp);
			errors++;
		end
	endtask

	task automatic check_period(input string name, input int act, exp);
		if (act != exp) begin
			$display("mismatch %s: got 0x%0h expected 0x%0h clocks", name, act, exp);
			errors++;
		end
	endtask

	// one instruction leaves the queue; count it against the fifo, drop masked ones
	task automatic add_expected(input int chan, input logic [W_DATA-1:0] data);
		accepted++;
		if (accepted <= keep_limit && cur_mask[chan])
			model.push_back(expected_frame(3'(chan), data, cur_mode));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus, all on the falling edge
	////////////////////////////////////////////////////////////////////////////

	task automatic drive_cycle(input logic [N_CHAN-1:0] vld, input logic [N_CHAN*W_DATA-1:0] pkd);
		@(negedge clk_in);
		data_valid  = vld;
		data_packed = pkd;
		for (int i = 0; i < N_CHAN; i++) begin   // lower half lands first
			if (vld[i])
				add_expected(i, pkd[i*W_DATA +: W_DATA]);
		end
	endtask

	task automatic drive_idle(input int n);
		repeat (n) begin
			@(negedge clk_in);
			data_valid = '0;
		end
	endtask

	function automatic logic [N_CHAN*W_DATA-1:0] random_bus();
		logic [N_CHAN*W_DATA-1:0] bus;
		for (int i = 0; i < N_CHAN; i++)
			bus[i*W_DATA +: W_DATA] = W_DATA'($urandom);
		return bus;
	endfunction

	task automatic reg_write(input logic [1:0] addr, input logic [W_CFG_DATA-1:0] wdata);
		@(negedge clk_in);
		cfg_wr    = 1'b1;
		cfg_addr  = addr;
		cfg_wdata = wdata;
		@(negedge clk_in);
		cfg_wr = 1'b0;
		case (addr)
			dac_pkg::REG_MASK: cur_mask = wdata;
			dac_pkg::REG_MODE: cur_mode = wdata[0];
			dac_pkg::REG_DIV:  cur_div  = wdata;
			default: ;
		endcase
	endtask

	task automatic read_check(input logic [1:0] addr, input logic [W_CFG_DATA-1:0] exp,
			input string name);
		@(negedge clk_in);
		cfg_addr = addr;
		#(CLK_PERIOD / 4);                     // read mux settled, no edge in between
		check_reg(name, cfg_rdata, exp);
	endtask

	// done once every owed frame is out and no further frame starts
	task automatic wait_drain();
		while (model.size() != 0)
			@(posedge clk_in);
		repeat (8) @(posedge clk_in);
		if (sync_n !== 1'b1) begin
			$display("error: a frame started after all expected frames were seen");
			errors++;
		end
	endtask

	task automatic start_test();
		err_mark = errors;
		tests_run++;
	endtask

	task automatic finish_test(input string name);
		if (errors != err_mark)
			tests_failed++;
		$display("test %0d %s: %s (%0d errors)", tests_run, name,
			(errors == err_mark) ? "ok" : "FAILED", errors - err_mark);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// frame capture, sdi taken on sclk rising edges
	////////////////////////////////////////////////////////////////////////////

	always @(negedge sync_n) begin
		cap_bits  = 0;
		cap_frame = '0;
	end

	always @(posedge sclk) begin
		if (sync_n === 1'b0) begin
			if (cap_bits > 0)
				check_period("sclk period", int'(($time - last_rise) / CLK_PERIOD),
					2 * (int'(cur_div) + 1));
			last_rise = $time;
			cap_frame = {cap_frame[W_FRAME-2:0], sdi};
			cap_bits++;
		end
	end

	// compare process, one model entry per finished frame
	always @(posedge sync_n) begin
		if (cap_bits != 0) begin
			if (cap_bits != W_FRAME) begin
				$display("error: frame ended after %0d sclk periods instead of %0d",
					cap_bits, W_FRAME);
				errors++;
			end else if (model.size() == 0) begin
				$display("error: frame 0x%06h arrived with no instruction expected", cap_frame);
				errors++;
			end else begin
				check_frame("sdi frame", cap_frame, model.pop_front());
			end
			cap_bits = 0;
		end
	end

	initial begin
		while (cycles < LIMIT) begin
			@(posedge clk_in);
			cycles++;
		end
		$display("error: run did not finish within %0d clock cycles", LIMIT);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		logic [N_CHAN-1:0] vld;
		logic              prev_hi;
		void'($urandom(32'h218e));
		data_packed = '0;
		data_valid  = '0;
		cfg_wr      = 1'b0;
		cfg_addr    = '0;
		cfg_wdata   = '0;
		cur_mask    = '1;
		cur_mode    = 1'b1;
		cur_div     = 8'd1;
		keep_limit  = 1 << 30;
		@(posedge rst_n);

		start_test();
		read_check(dac_pkg::REG_MASK, 8'hff, "cfg_rdata mask");
		read_check(dac_pkg::REG_MODE, 8'h01, "cfg_rdata mode");
		read_check(dac_pkg::REG_DIV, 8'h01, "cfg_rdata div");
		read_check(dac_pkg::REG_STATUS, 8'h00, "cfg_rdata status");
		finish_test("reset values");

		start_test();
		for (int c = 0; c < N_CHAN; c++)
			drive_cycle(N_CHAN'(1) << c, random_bus());
		drive_idle(1);
		wait_drain();
		finish_test("single strobes");

		start_test();
		drive_cycle(8'b0100_0010, random_bus());  // ch 2 with ch 7
		drive_idle(1);                            // no lower strobe after an upper one
		drive_cycle(8'b0001_1000, random_bus());  // ch 4 with ch 5
		drive_idle(1);
		wait_drain();
		finish_test("lower before upper");

		start_test();
		for (int d = 0; d < 2; d++) begin
			reg_write(dac_pkg::REG_DIV, (d == 0) ? 8'd0 : 8'd3);
			for (int b = 0; b < N_BURST; b++) begin
				prev_hi = 1'b0;
				for (int c = 0; c < BURST_LEN; c++) begin
					vld = '0;
					if (!prev_hi && $urandom_range(1, 0) == 1)
						vld[$urandom_range(3, 0)] = 1'b1;
					if ($urandom_range(1, 0) == 1)
						vld[4 + $urandom_range(3, 0)] = 1'b1;
					prev_hi = |vld[N_CHAN-1:N_CHAN/2];
					drive_cycle(vld, random_bus());
				end
				drive_idle(1);
				wait_drain();
			end
		end
		reg_write(dac_pkg::REG_DIV, 8'd1);
		finish_test("random bursts");

		start_test();
		reg_write(dac_pkg::REG_MASK, 8'b1010_0101);  // ch 1, 3, 6, 8 on
		reg_write(dac_pkg::REG_MODE, 8'h00);
		for (int c = 0; c < N_CHAN; c++)
			drive_cycle(N_CHAN'(1) << c, random_bus());
		drive_idle(1);
		wait_drain();
		reg_write(dac_pkg::REG_MASK, 8'hff);
		reg_write(dac_pkg::REG_MODE, 8'h01);
		finish_test("mask and mode");

		start_test();
		reg_write(dac_pkg::REG_DIV, 8'hff);          // slowest frames, fifo cannot drain
		accepted   = 0;
		keep_limit = FIFO_DEPTH + 1;                 // head popped plus a full fifo
		for (int c = 0; c < FIFO_DEPTH + 8; c++)
			drive_cycle(N_CHAN'(1) << (c % 4), random_bus());
		drive_idle(1);
		read_check(dac_pkg::REG_STATUS, 8'h01, "cfg_rdata status");
		wait_drain();
		reg_write(dac_pkg::REG_STATUS, 8'h00);
		read_check(dac_pkg::REG_STATUS, 8'h00, "cfg_rdata status");
		keep_limit = 1 << 30;
		reg_write(dac_pkg::REG_DIV, 8'd1);
		finish_test("fifo overflow");

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- compile.f
src/dac_pkg.sv
src/dac_instr_queue.sv
src/dac_instr_fifo.sv
src/dac_serial_ctrl.sv
src/dac_cfg_regs.sv
src/dac_out_top.sv
dv/dac_clk_gen.sv
dv/dac_out_tb.sv

//--- Makefile
# Verilator build and run for the dac output path

SIM      := verilator
TOP      := dac_out_tb
FILELIST := compile.f
FLAGS    := --binary --timing --top-module $(TOP)
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the grep status is the status of the target
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
